//--- filelist.f
+incdir+rtl
rtl/dma_xfer_pkg.sv
rtl/dma_burst_pkg.sv
rtl/page_chopper.sv
rtl/burst_coordinator.sv
rtl/dma_legalizer.sv
tests/legalizer_clk_gen.sv
tests/dma_legalizer_props.sv
tests/dma_legalizer_tb.sv

//--- rtl/burst_coordinator.sv
// --------------------
// joins the read and write choppers: mode and page options,
// allowed bytes, channel valids, pairing, kill and request accept
// --------------------

module burst_coordinator (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    // request channel control and options
    input  logic                      req_valid_i,
    input  logic                      req_decouple_rw_i,
    input  logic                      req_src_reduce_i,
    input  logic                      req_dst_reduce_i,
    input  dma_xfer_pkg::llen_t       req_src_llen_i,
    input  dma_xfer_pkg::llen_t       req_dst_llen_i,
    // chopper status
    input  dma_burst_pkg::page_len_t  r_to_boundary_i,
    input  dma_burst_pkg::page_len_t  w_to_boundary_i,
    input  logic                      r_busy_i,
    input  logic                      w_busy_i,
    // channel handshakes and global controls
    input  logic                      ar_ready_i,
    input  logic                      aw_ready_i,
    input  logic                      flush_i,
    input  logic                      kill_i,
    output logic                      req_ready_o,
    output logic                      load_o,
    output logic                      r_advance_o,
    output logic                      w_advance_o,
    output logic                      clear_o,
    output dma_xfer_pkg::page_opt_t   r_page_opt_o,
    output dma_xfer_pkg::page_opt_t   w_page_opt_o,
    output dma_burst_pkg::page_len_t  r_allowed_o,
    output dma_burst_pkg::page_len_t  w_allowed_o,
    output logic                      ar_valid_o,
    output logic                      aw_valid_o
);

    // options of the active transfer
    logic                      decouple_q;
    dma_xfer_pkg::page_opt_t   r_opt_q;
    dma_xfer_pkg::page_opt_t   w_opt_q;

    // coupled mode: this channel already fired for the current pair
    logic                      r_sent_q;
    logic                      w_sent_q;

    dma_burst_pkg::page_len_t  near_boundary;
    logic                      r_fire;
    logic                      w_fire;
    logic                      r_done;
    logic                      w_done;
    logic                      pair_done;

    // --------------------
    // request accept
    // --------------------
    // both sides idle, no burst emission held back
    assign req_ready_o = !r_busy_i && !w_busy_i && !flush_i;
    assign load_o      = req_valid_i && req_ready_o;
    assign clear_o     = kill_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            decouple_q <= 1'b0;
            r_opt_q    <= '0;
            w_opt_q    <= '0;
        end else if (load_o) begin
            decouple_q <= req_decouple_rw_i;
            r_opt_q    <= '{reduce: req_src_reduce_i, llen: req_src_llen_i};
            w_opt_q    <= '{reduce: req_dst_reduce_i, llen: req_dst_llen_i};
        end
    end

    assign r_page_opt_o = r_opt_q;
    assign w_page_opt_o = w_opt_q;

    // --------------------
    // allowed bytes
    // --------------------
    // coupled: both sides stop at the nearer boundary
    assign near_boundary = (r_to_boundary_i < w_to_boundary_i) ? r_to_boundary_i
                                                               : w_to_boundary_i;
    assign r_allowed_o   = decouple_q ? r_to_boundary_i : near_boundary;
    assign w_allowed_o   = decouple_q ? w_to_boundary_i : near_boundary;

    // --------------------
    // channel valids
    // --------------------
    // sent flags stay clear in decoupled mode
    assign ar_valid_o = r_busy_i && !r_sent_q && !flush_i;
    assign aw_valid_o = w_busy_i && !w_sent_q && !flush_i;

    assign r_fire = ar_valid_o && ar_ready_i;
    assign w_fire = aw_valid_o && aw_ready_i;

    // a pair completes once both halves have fired, in any order
    assign r_done    = r_sent_q || r_fire;
    assign w_done    = w_sent_q || w_fire;
    assign pair_done = r_done && w_done;

    assign r_advance_o = decouple_q ? r_fire : pair_done;
    assign w_advance_o = decouple_q ? w_fire : pair_done;

    // remember a lone handshake until the partner catches up
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            r_sent_q <= 1'b0;
            w_sent_q <= 1'b0;
        end else if (kill_i || load_o || decouple_q || pair_done) begin
            r_sent_q <= 1'b0;
            w_sent_q <= 1'b0;
        end else begin
            r_sent_q <= r_done;
            w_sent_q <= w_done;
        end
    end

endmodule

//--- rtl/dma_burst_pkg.sv
// --------------------
// types of the emitted AXI4 bursts
// --------------------
`include "dma_legal_macros.svh"

package dma_burst_pkg;

    // byte count up to and including one full page
    // one extra bit so that 4096 itself fits
    typedef logic [`DL_PAGE_W:0] page_len_t;

    // AXI4 len field, number of beats minus one
    typedef logic [$clog2(`DL_MAX_BEATS)-1:0] beats_t;

    // byte position inside one data beat
    typedef logic [`DL_OFFSET_W-1:0] offset_t;

endpackage

//--- rtl/dma_legal_macros.svh
// --------------------
// constants shared by the burst legalizer
// beat size, address and length widths, page and burst limits
// --------------------
`ifndef DMA_LEGAL_MACROS_SVH
`define DMA_LEGAL_MACROS_SVH

// bytes moved per data beat
`define DL_DATA_BYTES 16
// byte address and transfer length widths
`define DL_ADDR_W 32
`define DL_LEN_W 32
// AXI4 limits: 256 beats per burst, 4 KiB pages
`define DL_MAX_BEATS 256
`define DL_PAGE_BYTES 4096
// log2 widths derived from the limits above
`define DL_OFFSET_W 4
`define DL_PAGE_W 12
`define DL_FULL_LLEN 8

`endif

//--- rtl/dma_legalizer.sv
// --------------------
// AXI4 burst legalizer top: read and write choppers
// tied together by the burst coordinator
// --------------------

module dma_legalizer (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    // 1D copy request
    input  logic                     req_valid_i,
    output logic                     req_ready_o,
    input  dma_xfer_pkg::len_t       req_length_i,
    input  dma_xfer_pkg::addr_t      req_src_addr_i,
    input  dma_xfer_pkg::addr_t      req_dst_addr_i,
    input  logic                     req_decouple_rw_i,
    input  logic                     req_src_reduce_i,
    input  dma_xfer_pkg::llen_t      req_src_llen_i,
    input  logic                     req_dst_reduce_i,
    input  dma_xfer_pkg::llen_t      req_dst_llen_i,
    // read burst channel
    output logic                     ar_valid_o,
    input  logic                     ar_ready_i,
    output dma_xfer_pkg::addr_t      ar_addr_o,
    output dma_burst_pkg::beats_t    ar_len_o,
    // write burst channel
    output logic                     aw_valid_o,
    input  logic                     aw_ready_i,
    output dma_xfer_pkg::addr_t      aw_addr_o,
    output dma_burst_pkg::beats_t    aw_len_o,
    output logic                     aw_last_o,
    // global controls and status
    input  logic                     flush_i,
    input  logic                     kill_i,
    output logic                     r_busy_o,
    output logic                     w_busy_o
);

    // coordinator to choppers
    logic                      load;
    logic                      clear;
    logic                      r_advance;
    logic                      w_advance;
    dma_xfer_pkg::page_opt_t   r_page_opt;
    dma_xfer_pkg::page_opt_t   w_page_opt;
    dma_burst_pkg::page_len_t  r_allowed;
    dma_burst_pkg::page_len_t  w_allowed;

    // choppers to coordinator
    dma_burst_pkg::page_len_t  r_to_boundary;
    dma_burst_pkg::page_len_t  w_to_boundary;

    // --------------------
    // read side, source address
    // --------------------
    page_chopper u_read_chopper (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .load_i        (load),
        .load_addr_i   (req_src_addr_i),
        .load_len_i    (req_length_i),
        .page_opt_i    (r_page_opt),
        .allowed_i     (r_allowed),
        .advance_i     (r_advance),
        .clear_i       (clear),
        .to_boundary_o (r_to_boundary),
        .burst_addr_o  (ar_addr_o),
        .burst_len_o   (ar_len_o),
        .final_o       (),
        .busy_o        (r_busy_o)
    );

    // --------------------
    // write side, destination address
    // --------------------
    // final chunk of this side marks the last burst of the transfer
    page_chopper u_write_chopper (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .load_i        (load),
        .load_addr_i   (req_dst_addr_i),
        .load_len_i    (req_length_i),
        .page_opt_i    (w_page_opt),
        .allowed_i     (w_allowed),
        .advance_i     (w_advance),
        .clear_i       (clear),
        .to_boundary_o (w_to_boundary),
        .burst_addr_o  (aw_addr_o),
        .burst_len_o   (aw_len_o),
        .final_o       (aw_last_o),
        .busy_o        (w_busy_o)
    );

    // --------------------
    // pairing and flow control
    // --------------------
    burst_coordinator u_coordinator (
        .clk_i             (clk_i),
        .rst_n_i           (rst_n_i),
        .req_valid_i       (req_valid_i),
        .req_decouple_rw_i (req_decouple_rw_i),
        .req_src_reduce_i  (req_src_reduce_i),
        .req_dst_reduce_i  (req_dst_reduce_i),
        .req_src_llen_i    (req_src_llen_i),
        .req_dst_llen_i    (req_dst_llen_i),
        .r_to_boundary_i   (r_to_boundary),
        .w_to_boundary_i   (w_to_boundary),
        .r_busy_i          (r_busy_o),
        .w_busy_i          (w_busy_o),
        .ar_ready_i        (ar_ready_i),
        .aw_ready_i        (aw_ready_i),
        .flush_i           (flush_i),
        .kill_i            (kill_i),
        .req_ready_o       (req_ready_o),
        .load_o            (load),
        .r_advance_o       (r_advance),
        .w_advance_o       (w_advance),
        .clear_o           (clear),
        .r_page_opt_o      (r_page_opt),
        .w_page_opt_o      (w_page_opt),
        .r_allowed_o       (r_allowed),
        .w_allowed_o       (w_allowed),
        .ar_valid_o        (ar_valid_o),
        .aw_valid_o        (aw_valid_o)
    );

endmodule

//--- rtl/dma_xfer_pkg.sv
// --------------------
// types of the incoming 1D copy request
// addresses, byte lengths and per-side page options
// --------------------
`include "dma_legal_macros.svh"

package dma_xfer_pkg;

    // --------------------
    // request payload
    // --------------------

    // byte address on either side of the copy
    typedef logic [`DL_ADDR_W-1:0] addr_t;

    // remaining byte count of a transfer
    typedef logic [`DL_LEN_W-1:0] len_t;

    // --------------------
    // page reduction
    // --------------------

    // log2 of the beat count of a reduced page
    // values up to 7, so a reduced page is always below 4 KiB
    typedef logic [2:0] llen_t;

    // page option of one side
    // reduce set: the page holds 2**llen beats
    // reduce clear: the full AXI4 page applies
    typedef struct packed {
        logic  reduce;
        llen_t llen;
    } page_opt_t;

endpackage

//--- rtl/page_chopper.sv
// --------------------
// one side of the legalizer: mutable address and length,
// distance to the next page boundary and burst formation
// --------------------
`include "dma_legal_macros.svh"

module page_chopper (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    // new transfer from the request channel
    input  logic                      load_i,
    input  dma_xfer_pkg::addr_t       load_addr_i,
    input  dma_xfer_pkg::len_t        load_len_i,
    input  dma_xfer_pkg::page_opt_t   page_opt_i,
    // bytes this side may move in the current burst
    input  dma_burst_pkg::page_len_t  allowed_i,
    // burst accepted, step to the next one
    input  logic                      advance_i,
    // drop the active transfer
    input  logic                      clear_i,
    output dma_burst_pkg::page_len_t  to_boundary_o,
    output dma_xfer_pkg::addr_t       burst_addr_o,
    output dma_burst_pkg::beats_t     burst_len_o,
    output logic                      final_o,
    output logic                      busy_o
);

    // transfer state
    dma_xfer_pkg::addr_t       addr_q;
    dma_xfer_pkg::len_t        len_q;
    logic                      busy_q;

    // page geometry
    logic [3:0]                page_w_raw;
    logic [3:0]                page_w;
    dma_burst_pkg::page_len_t  page_size;
    logic [`DL_PAGE_W-1:0]     page_off;

    // current burst
    dma_burst_pkg::page_len_t  chunk;
    dma_burst_pkg::offset_t    beat_off;
    dma_burst_pkg::page_len_t  span;

    // --------------------
    // page boundary
    // --------------------
    always_comb begin
        // offset bits plus the beat bits of the page
        page_w_raw = 4'(`DL_OFFSET_W) +
                     (page_opt_i.reduce ? 4'(page_opt_i.llen) : 4'(`DL_FULL_LLEN));
        // never larger than the 4 KiB AXI page
        page_w = (page_w_raw > 4'(`DL_PAGE_W)) ? 4'(`DL_PAGE_W) : page_w_raw;
    end

    // page of 2**page_w bytes, the extra bit holds a full 4 KiB
    assign page_size = dma_burst_pkg::page_len_t'(1) << page_w;

    // address bits below the page width, the rest masked off
    always_comb begin
        page_off = '0;
        for (int i = 0; i < `DL_PAGE_W; i++) begin
            page_off[i] = (page_w > i) ? addr_q[i] : 1'b0;
        end
    end

    assign to_boundary_o = page_size - dma_burst_pkg::page_len_t'(page_off);

    // --------------------
    // burst formation
    // --------------------
    // last chunk once the remainder fits in the allowed bytes
    assign final_o = (len_q <= dma_xfer_pkg::len_t'(allowed_i));
    assign chunk   = final_o ? dma_burst_pkg::page_len_t'(len_q) : allowed_i;

    assign beat_off = addr_q[`DL_OFFSET_W-1:0];
    // bytes touched from the aligned start, minus one
    assign span     = chunk + dma_burst_pkg::page_len_t'(beat_off) - 1'b1;

    assign burst_addr_o = addr_q & ~dma_xfer_pkg::addr_t'(`DL_DATA_BYTES - 1);
    assign burst_len_o  = dma_burst_pkg::beats_t'(span >> `DL_OFFSET_W);
    assign busy_o       = busy_q;

    // --------------------
    // state update
    // --------------------
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            busy_q <= 1'b0;
        end else if (load_i) begin
            busy_q <= 1'b1;
        end else if (clear_i) begin
            busy_q <= 1'b0;
        end else if (advance_i && final_o) begin
            busy_q <= 1'b0;
        end
    end

    // address and remainder carry no reset, busy qualifies them
    always_ff @(posedge clk_i) begin
        if (load_i) begin
            addr_q <= load_addr_i;
            len_q  <= load_len_i;
        end else if (advance_i) begin
            addr_q <= addr_q + dma_xfer_pkg::addr_t'(chunk);
            len_q  <= len_q - dma_xfer_pkg::len_t'(chunk);
        end
    end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# build the legalizer testbench with Verilator, run it, look for the pass line in sim.log
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log \
    && verilator --binary --timing --assert -Wno-fatal --top-module dma_legalizer_tb \
        -f filelist.f -o dma_legalizer_sim \
    && { ./obj_dir/dma_legalizer_sim > sim.log 2>&1 || true; } \
    && cat sim.log \
    && grep -qx "Test passed" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }

//--- tests/dma_legalizer_props.sv
// --------------------
// handshake, reset and accept properties of the legalizer
// bound into every dma_legalizer instance
// --------------------
module dma_legalizer_props (
    input logic                   clk_i,
    input logic                   rst_n_i,
    input logic                   kill_i,
    input logic                   req_ready_o,
    input logic                   ar_valid_o,
    input logic                   ar_ready_i,
    input dma_xfer_pkg::addr_t    ar_addr_o,
    input dma_burst_pkg::beats_t  ar_len_o,
    input logic                   aw_valid_o,
    input logic                   aw_ready_i,
    input dma_xfer_pkg::addr_t    aw_addr_o,
    input dma_burst_pkg::beats_t  aw_len_o,
    input logic                   aw_last_o,
    input logic                   r_busy_o,
    input logic                   w_busy_o
);
    timeunit 1ns;
    timeprecision 1ps;

    // --------------------
    // channel stability
    // --------------------
    // a pending read burst waits for ar_ready_i, only kill drops it
    ar_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (ar_valid_o && !ar_ready_i && !kill_i) |=>
            (ar_valid_o && $stable(ar_addr_o) && $stable(ar_len_o)))
        else $error("ar burst changed or dropped before ar_ready_i");

    // same for the write side, last marker included
    aw_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (aw_valid_o && !aw_ready_i && !kill_i) |=>
            (aw_valid_o && $stable(aw_addr_o) && $stable(aw_len_o) && $stable(aw_last_o)))
        else $error("aw burst changed or dropped before aw_ready_i");

    // --------------------
    // reset and accept
    // --------------------
    // first cycle out of reset: nothing busy, nothing valid
    reset_idle: assert property (@(posedge clk_i)
        $rose(rst_n_i) |-> (!ar_valid_o && !aw_valid_o && !r_busy_o && !w_busy_o))
        else $error("legalizer not idle after reset");

    // new requests only when both sides are idle
    ready_idle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(req_ready_o && (r_busy_o || w_busy_o)))
        else $error("req_ready_o high while a side is busy");

endmodule

bind dma_legalizer dma_legalizer_props u_props (.*);

//--- tests/dma_legalizer_tb.sv
// --------------------
// burst legalizer testbench: directed and random copy requests,
// reference burst model, handshake monitor, kill, flush and timeout
// --------------------
`include "dma_legal_macros.svh"

module dma_legalizer_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_REQ  = 20;
    localparam int KILL_IDX = 5;
    // requests from here on are random, with stalls and flush pulses
    localparam int RAND_IDX = 7;

    logic                   clk_i;
    logic                   rst_n_i;
    logic                   req_valid_i;
    logic                   req_ready_o;
    dma_xfer_pkg::len_t     req_length_i;
    dma_xfer_pkg::addr_t    req_src_addr_i;
    dma_xfer_pkg::addr_t    req_dst_addr_i;
    logic                   req_decouple_rw_i;
    logic                   req_src_reduce_i;
    dma_xfer_pkg::llen_t    req_src_llen_i;
    logic                   req_dst_reduce_i;
    dma_xfer_pkg::llen_t    req_dst_llen_i;
    logic                   ar_valid_o;
    logic                   ar_ready_i;
    dma_xfer_pkg::addr_t    ar_addr_o;
    dma_burst_pkg::beats_t  ar_len_o;
    logic                   aw_valid_o;
    logic                   aw_ready_i;
    dma_xfer_pkg::addr_t    aw_addr_o;
    dma_burst_pkg::beats_t  aw_len_o;
    logic                   aw_last_o;
    logic                   flush_i;
    logic                   kill_i;
    logic                   r_busy_o;
    logic                   w_busy_o;

    // request table
    logic [31:0] req_len [NUM_REQ];
    logic [31:0] req_src [NUM_REQ];
    logic [31:0] req_dst [NUM_REQ];
    logic [2:0]  req_sl [NUM_REQ];
    logic [2:0]  req_dl [NUM_REQ];
    bit          req_dec [NUM_REQ];
    bit          req_sr [NUM_REQ];
    bit          req_dr [NUM_REQ];

    // expected bursts, oldest first
    logic [31:0] exp_ar_addr [$];
    logic [7:0]  exp_ar_len [$];
    logic [31:0] exp_aw_addr [$];
    logic [7:0]  exp_aw_len [$];
    bit          exp_aw_last [$];

    int          mismatch_count = 0;
    int          other_count = 0;
    int          accept_count = 0;
    int unsigned cycle_count = 0;
    int unsigned timeout_limit = 32'hffff_ffff;
    bit          stall_en = 1'b0;

    legalizer_clk_gen u_clk_gen (.clk_o(clk_i), .rst_n_o(rst_n_i));

    dma_legalizer dma_legalizer_i (.*);

    // --------------------
    // reference model
    // --------------------
    // bytes left up to this side's page boundary
    function automatic int unsigned boundary_distance(input logic [31:0] addr,
                                                      input bit reduce, input logic [2:0] llen);
        int unsigned width;
        int unsigned page;
        width = `DL_OFFSET_W + (reduce ? int'(llen) : `DL_FULL_LLEN);
        if (width > `DL_PAGE_W) begin
            width = `DL_PAGE_W;
        end
        page = 1 << width;
        return page - (addr % page);
    endfunction

    // side 0 walks the source, side 1 the destination
    function automatic void ref_bursts(input int i);
        logic [31:0] rem;
        logic [31:0] ra;
        logic [31:0] wa;
        logic [31:0] addr;
        logic [31:0] chunk;
        int unsigned rd;
        int unsigned wd;
        int unsigned allowed;
        for (int side = 0; side < 2; side++) begin
            rem = req_len[i];
            ra  = req_src[i];
            wa  = req_dst[i];
            while (rem != 0) begin
                rd = boundary_distance(ra, req_sr[i], req_sl[i]);
                wd = boundary_distance(wa, req_dr[i], req_dl[i]);
                if (req_dec[i]) begin
                    allowed = (side == 0) ? rd : wd;
                end else begin
                    allowed = (rd < wd) ? rd : wd;
                end
                chunk = (rem < allowed) ? rem : allowed;
                addr  = (side == 0) ? ra : wa;
                if (side == 0) begin
                    exp_ar_addr.push_back(addr & ~32'(`DL_DATA_BYTES - 1));
                    exp_ar_len.push_back(8'((chunk + addr % `DL_DATA_BYTES - 1) >> `DL_OFFSET_W));
                end else begin
                    exp_aw_addr.push_back(addr & ~32'(`DL_DATA_BYTES - 1));
                    exp_aw_len.push_back(8'((chunk + addr % `DL_DATA_BYTES - 1) >> `DL_OFFSET_W));
                    exp_aw_last.push_back(chunk == rem);
                end
                ra  = ra + chunk;
                wa  = wa + chunk;
                rem = rem - chunk;
            end
        end
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            mismatch_count++;
            $display("error %s expected %h actual %h", name, expected, actual);
        end
    endtask

    // --------------------
    // monitor and watchdog
    // --------------------
    // handshakes are sampled on the rising edge, one queue entry each
    always @(posedge clk_i) begin
        if (rst_n_i) begin
            if (req_valid_i && req_ready_o) begin
                accept_count++;
            end
            if (ar_valid_o && ar_ready_i) begin
                if (exp_ar_addr.size() == 0) begin
                    other_count++;
                    $display("read burst issued when none was expected");
                end else begin
                    check_value("ar_addr_o", exp_ar_addr.pop_front(), ar_addr_o);
                    check_value("ar_len_o", exp_ar_len.pop_front(), ar_len_o);
                end
            end
            if (aw_valid_o && aw_ready_i) begin
                if (exp_aw_addr.size() == 0) begin
                    other_count++;
                    $display("write burst issued when none was expected");
                end else begin
                    check_value("aw_addr_o", exp_aw_addr.pop_front(), aw_addr_o);
                    check_value("aw_len_o", exp_aw_len.pop_front(), aw_len_o);
                    check_value("aw_last_o", exp_aw_last.pop_front(), aw_last_o);
                end
            end
        end
    end

    always @(posedge clk_i) begin
        cycle_count++;
        if (cycle_count >= timeout_limit) begin
            $display("run stopped after %0d cycles without finishing", cycle_count);
            $display("Test failed");
            $finish;
        end
    end

    // --------------------
    // stimulus
    // --------------------
    // inputs change on the falling edge, random readies when stalling
    task automatic next_cycle();
        @(negedge clk_i);
        if (stall_en) begin
            ar_ready_i = ($urandom % 4) != 0;
            aw_ready_i = ($urandom % 4) != 0;
        end
    endtask

    task automatic set_request(input int i, input logic [31:0] len, input logic [31:0] src,
                               input logic [31:0] dst, input bit dec, input bit sr,
                               input logic [2:0] sl, input bit dr, input logic [2:0] dl);
        req_len[i] = len;
        req_src[i] = src;
        req_dst[i] = dst;
        req_dec[i] = dec;
        req_sr[i]  = sr;
        req_sl[i]  = sl;
        req_dr[i]  = dr;
        req_dl[i]  = dl;
    endtask

    task automatic run_request(input int i);
        int flush_len;
        int seen;
        stall_en   = (i >= RAND_IDX);
        ar_ready_i = 1'b1;
        aw_ready_i = 1'b1;
        flush_len  = stall_en ? int'($urandom % 4) : 0;
        req_length_i      = req_len[i];
        req_src_addr_i    = req_src[i];
        req_dst_addr_i    = req_dst[i];
        req_decouple_rw_i = req_dec[i];
        req_src_reduce_i  = req_sr[i];
        req_src_llen_i    = req_sl[i];
        req_dst_reduce_i  = req_dr[i];
        req_dst_llen_i    = req_dl[i];
        req_valid_i       = 1'b1;
        ref_bursts(i);
        seen = accept_count;
        // flush holds the request back while the sides are idle
        flush_i = (flush_len != 0);
        repeat (flush_len) begin
            next_cycle();
            check_value("req_ready_o", 0, req_ready_o);
            check_value("ar_valid_o", 0, ar_valid_o);
        end
        flush_i = 1'b0;
        while (accept_count == seen) begin
            next_cycle();
        end
        req_valid_i = 1'b0;
        if (i == KILL_IDX) begin
            repeat (12) next_cycle();
            // readies low so no burst slips through on the kill edge
            ar_ready_i = 1'b0;
            aw_ready_i = 1'b0;
            kill_i     = 1'b1;
            next_cycle();
            kill_i = 1'b0;
            check_value("r_busy_o", 0, r_busy_o);
            check_value("w_busy_o", 0, w_busy_o);
            exp_ar_addr.delete();
            exp_ar_len.delete();
            exp_aw_addr.delete();
            exp_aw_len.delete();
            exp_aw_last.delete();
        end
        while (r_busy_o || w_busy_o) begin
            next_cycle();
        end
        check_value("ar bursts left", 0, exp_ar_addr.size());
        check_value("aw bursts left", 0, exp_aw_addr.size());
    endtask

    initial begin
        int unsigned total;
        void'($urandom(17328));
        req_valid_i = 1'b0;
        req_length_i = '0;
        req_src_addr_i = '0;
        req_dst_addr_i = '0;
        req_decouple_rw_i = 1'b0;
        req_src_reduce_i = 1'b0;
        req_src_llen_i = '0;
        req_dst_reduce_i = 1'b0;
        req_dst_llen_i = '0;
        ar_ready_i = 1'b1;
        aw_ready_i = 1'b1;
        flush_i = 1'b0;
        kill_i = 1'b0;
        // one page, then coupled and decoupled crossings, reduced pages, kill
        set_request(0, 40, 32'h1000_0104, 32'h2000_0208, 0, 0, 0, 0, 0);
        set_request(1, 9000, 32'h0001_0f30, 32'h0002_3a08, 0, 0, 0, 0, 0);
        set_request(2, 7000, 32'h0003_0abc, 32'h0004_1f05, 1, 0, 0, 0, 0);
        set_request(3, 2000, 32'h5000_0013, 32'h6000_01f1, 0, 1, 3, 1, 5);
        set_request(4, 300, 32'h7000_0007, 32'h8000_0ff0, 1, 1, 0, 0, 0);
        set_request(5, 65536, 32'h9000_0000, 32'ha000_0800, 0, 0, 0, 0, 0);
        set_request(6, 5000, 32'h9000_0010, 32'ha000_0ff8, 0, 0, 0, 0, 0);
        for (int i = RAND_IDX; i < NUM_REQ; i++) begin
            set_request(i, 1 + $urandom % 6000, $urandom, $urandom, 1'($urandom),
                        1'($urandom), 3'($urandom), 1'($urandom), 3'($urandom));
        end
        // timeout from the full burst count of all requests
        total = 0;
        for (int i = 0; i < NUM_REQ; i++) begin
            ref_bursts(i);
            total += exp_ar_addr.size() + exp_aw_addr.size();
            exp_ar_addr.delete();
            exp_ar_len.delete();
            exp_aw_addr.delete();
            exp_aw_len.delete();
            exp_aw_last.delete();
        end
        timeout_limit = total * 20 + 2000;
        @(posedge rst_n_i);
        next_cycle();
        for (int i = 0; i < NUM_REQ; i++) begin
            run_request(i);
        end
        $display("checks done: %0d value errors, %0d other errors", mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- tests/legalizer_clk_gen.sv
// --------------------
// testbench clock, 8 ns period
// reset held low for 8 cycles
// --------------------
module legalizer_clk_gen (
    output logic clk_o,
    output logic rst_n_o
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk_o = 1'b0;
        forever begin
            #4 clk_o = ~clk_o;
        end
    end

    // release on a falling edge, away from the sampling edge
    initial begin
        rst_n_o = 1'b0;
        repeat (8) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end

endmodule
